//--- project.f
+incdir+.
ic_xbar_pkg.sv
ic_rr_arbiter.sv
ic_request_block.sv
ic_addr_decoder_req.sv
ic_resp_block.sv
ic_xbar_top.sv
tb_ic_xbar.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the crossbar testbench with Verilator and run it.
# Exits with a failing status unless the run reports the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_ic_xbar -f project.f -o sim_ic_xbar

out="$(./obj_dir/sim_ic_xbar)"
echo "$out"

if echo "$out" | grep -qx "No errors"; then
   exit 0
else
   exit 1
fi

//--- tb_ic_xbar.sv
// Directed testbench for the instruction-cache crossbar.
// Models one memory bank behind every bank port and drives the fetch masters
// through single, conflicting, parallel, stalled and random reads.
// Ends with one line of check and error counts and the verdict.

`include "ic_xbar_macros.svh"

module tb_ic_xbar;

   import ic_xbar_pkg::*;

   localparam int NM = `IC_N_MASTER;
   localparam int NB = `IC_N_BANK;
   localparam int RAND_CYCLES = 200;

   // Bank model answers with the address under this mask
   localparam logic [31:0] DATA_MASK = 32'h5a5a_0000;

   logic                  clk;
   logic                  arst_n;
   logic [NM-1:0]         m_req;
   addr_t [NM-1:0]        m_add;
   logic [NM-1:0]         m_gnt;
   logic [NM-1:0]         m_r_valid;
   rdata_t [NM-1:0]       m_r_rdata;
   logic [NB-1:0]         b_req;
   addr_t [NB-1:0]        b_add;
   master_id_t [NB-1:0]   b_id;
   logic [NB-1:0]         b_gnt;
   logic [NB-1:0]         b_r_valid = '0;
   master_id_t [NB-1:0]   b_r_id    = '0;
   rdata_t [NB-1:0]       b_r_rdata = '0;

   // Per-bank flag that holds the bank grant low
   logic [NB-1:0]         stall;

   integer                seed;
   int                    errors;
   int                    checks;

   ic_xbar_top DUT
   (
      .clk         ( clk       ),
      .arst_n_i    ( arst_n    ),
      .m_req_i     ( m_req     ),
      .m_add_i     ( m_add     ),
      .m_gnt_o     ( m_gnt     ),
      .m_r_valid_o ( m_r_valid ),
      .m_r_rdata_o ( m_r_rdata ),
      .b_req_o     ( b_req     ),
      .b_add_o     ( b_add     ),
      .b_id_o      ( b_id      ),
      .b_gnt_i     ( b_gnt     ),
      .b_r_valid_i ( b_r_valid ),
      .b_r_id_i    ( b_r_id    ),
      .b_r_rdata_i ( b_r_rdata )
   );

   always #10 clk = ~clk;

   ////////////////////////////////////////
   // Bank model
   ////////////////////////////////////////

   // Grant in the same cycle unless stalled
   assign b_gnt = ~stall;

   // Accepts are sampled at the edge and answered just after it
   always @(posedge clk)
   begin : bank_model
      logic [NB-1:0]       acc;
      master_id_t [NB-1:0] id_s;
      rdata_t [NB-1:0]     rd_s;
      acc = b_req & b_gnt & {NB{arst_n}};
      for (int b = 0; b < NB; b++)
      begin
         id_s[b] = b_id[b];
         rd_s[b] = b_add[b] ^ DATA_MASK;
      end
      #2;
      b_r_valid = acc;
      b_r_id    = id_s;
      b_r_rdata = rd_s;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic check_val(input string what, input logic [31:0] exp,
                            input logic [31:0] act);
      checks++;
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %h, actual %h", what, exp, act);
         errors++;
      end
   endtask

   // Inputs change a little after the rising edge
   task automatic advance_cycle;
      @(posedge clk);
      #2;
   endtask

   // Random word address whose interleave bits name the given bank
   function automatic addr_t addr_in_bank(input int bank);
      addr_t a;
      a = addr_t'($random(seed));
      a[`IC_BANK_LSB +: BANK_IDX_W] = bank_idx_t'(bank);
      return a;
   endfunction

   function automatic int onehot_index(input logic [NM-1:0] v);
      int idx;
      idx = -1;
      for (int i = 0; i < NM; i++)
      begin
         if (v[i])
            idx = i;
      end
      return idx;
   endfunction

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   // Every master reads once from every bank
   task automatic single_access;
      addr_t a;
      for (int m = 0; m < NM; m++)
      begin
         for (int b = 0; b < NB; b++)
         begin
            a        = addr_in_bank(b);
            m_req[m] = 1'b1;
            m_add[m] = a;
            @(negedge clk);
            check_val("single_access gnt", 32'(1 << m), 32'(m_gnt));
            check_val("single_access bank req", 32'(1 << b), 32'(b_req));
            check_val("single_access bank addr", a, b_add[b]);
            check_val("single_access bank id", 32'(1 << m), 32'(b_id[b]));
            advance_cycle();
            m_req[m] = 1'b0;
            @(negedge clk);
            // Response only at the requesting master
            check_val("single_access r_valid", 32'(1 << m), 32'(m_r_valid));
            check_val("single_access rdata", a ^ DATA_MASK, m_r_rdata[m]);
            advance_cycle();
         end
      end
   endtask

   // All masters hit one bank and hold their requests until granted
   task automatic bank_conflict;
      addr_t         a [NM];
      logic [NM-1:0] served;
      logic [NM-1:0] g;
      int            cb;
      int            pm;
      int            nxt;
      int            prev;
      int            win;
      int            cyc;
      cb = 1 % NB;
      pm = 1 % NM;
      // A lone access moves the pointer so that the winners wrap past the top
      m_req[pm] = 1'b1;
      m_add[pm] = addr_in_bank(cb);
      @(negedge clk);
      check_val("bank_conflict lone gnt", 32'(1 << pm), 32'(m_gnt));
      advance_cycle();
      m_req[pm] = 1'b0;
      advance_cycle();
      for (int m = 0; m < NM; m++)
      begin
         a[m]     = addr_in_bank(cb);
         m_add[m] = a[m];
      end
      m_req  = '1;
      served = '0;
      prev   = -1;
      nxt    = (pm + 1) % NM;
      cyc    = 0;
      while (served != {NM{1'b1}} && cyc < NM)
      begin
         @(negedge clk);
         // Last cycle's winner gets its data now
         if (prev >= 0)
         begin
            check_val("bank_conflict r_valid", 32'(1 << prev), 32'(m_r_valid));
            check_val("bank_conflict rdata", a[prev] ^ DATA_MASK, m_r_rdata[prev]);
         end
         else
            check_val("bank_conflict r_valid", 0, 32'(m_r_valid));
         g = m_gnt;
         checks++;
         if (!$onehot(g))
         begin
            $display("[ERROR] bank_conflict: grants %b in one cycle, not exactly one", g);
            errors++;
         end
         else
         begin
            win = onehot_index(g);
            // Round robin starts just past the last winner and wraps at the top
            check_val("bank_conflict winner", 32'(nxt), 32'(win));
            served = served | g;
            prev   = win;
            nxt    = (win + 1) % NM;
         end
         advance_cycle();
         m_req = m_req & ~g;
         cyc++;
      end
      checks++;
      if (served != {NM{1'b1}})
      begin
         $display("[ERROR] bank_conflict: not every master was served in %0d cycles", NM);
         errors++;
      end
      m_req = '0;
      @(negedge clk);
      if (prev >= 0)
      begin
         check_val("bank_conflict last r_valid", 32'(1 << prev), 32'(m_r_valid));
         check_val("bank_conflict last rdata", a[prev] ^ DATA_MASK, m_r_rdata[prev]);
      end
      advance_cycle();
   endtask

   // Each master on its own bank and all served together
   task automatic parallel_banks;
      addr_t a [NM];
      for (int m = 0; m < NM; m++)
      begin
         a[m]     = addr_in_bank(m % NB);
         m_add[m] = a[m];
      end
      m_req = '1;
      @(negedge clk);
      check_val("parallel_banks gnt", 32'({NM{1'b1}}), 32'(m_gnt));
      advance_cycle();
      m_req = '0;
      @(negedge clk);
      check_val("parallel_banks r_valid", 32'({NM{1'b1}}), 32'(m_r_valid));
      for (int m = 0; m < NM; m++)
         check_val("parallel_banks rdata", a[m] ^ DATA_MASK, m_r_rdata[m]);
      advance_cycle();
   endtask

   // Master 0 waits on a stalled bank while master 1 uses another one
   task automatic back_pressure;
      addr_t a0;
      addr_t a1;
      int    sb;
      int    cnt;
      sb        = 2 % NB;
      a0        = addr_in_bank(sb);
      a1        = addr_in_bank(3 % NB);
      stall[sb] = 1'b1;
      m_req[0]  = 1'b1;
      m_add[0]  = a0;
      m_req[1]  = 1'b1;
      m_add[1]  = a1;
      for (int k = 0; k < 4; k++)
      begin
         @(negedge clk);
         check_val("back_pressure stalled gnt", 0, 32'(m_gnt[0]));
         check_val("back_pressure stalled r_valid", 0, 32'(m_r_valid[0]));
         check_val("back_pressure stalled bank req", 1, 32'(b_req[sb]));
         if (k == 0)
            check_val("back_pressure other gnt", 1, 32'(m_gnt[1]));
         if (k == 1)
         begin
            check_val("back_pressure other r_valid", 1, 32'(m_r_valid[1]));
            check_val("back_pressure other rdata", a1 ^ DATA_MASK, m_r_rdata[1]);
         end
         advance_cycle();
         if (k == 0)
            m_req[1] = 1'b0;
      end
      stall[sb] = 1'b0;
      cnt       = 0;
      @(negedge clk);
      while (!m_gnt[0] && cnt < 8)
      begin
         @(negedge clk);
         cnt++;
      end
      checks++;
      if (!m_gnt[0])
      begin
         $display("[ERROR] back_pressure: stalled request not granted after release");
         errors++;
      end
      advance_cycle();
      m_req[0] = 1'b0;
      @(negedge clk);
      check_val("back_pressure released r_valid", 1, 32'(m_r_valid[0]));
      check_val("back_pressure released rdata", a0 ^ DATA_MASK, m_r_rdata[0]);
      advance_cycle();
   endtask

   // Back-to-back random reads against a one-deep scoreboard per master
   task automatic random_traffic;
      logic [NM-1:0] pend;
      rdata_t        exp_d [NM];
      int            accepts;
      int            resps;
      pend    = '0;
      accepts = 0;
      resps   = 0;
      for (int m = 0; m < NM; m++)
      begin
         m_req[m] = (($random(seed) & 3) != 0);
         m_add[m] = addr_t'($random(seed));
      end
      for (int c = 0; c <= RAND_CYCLES; c++)
      begin
         @(negedge clk);
         for (int m = 0; m < NM; m++)
         begin
            check_val("random_traffic r_valid", 32'(pend[m]), 32'(m_r_valid[m]));
            if (pend[m] && m_r_valid[m])
            begin
               check_val("random_traffic rdata", exp_d[m], m_r_rdata[m]);
               resps++;
            end
            // Record this cycle's accept
            pend[m] = m_req[m] & m_gnt[m];
            if (pend[m])
            begin
               exp_d[m] = m_add[m] ^ DATA_MASK;
               accepts++;
            end
         end
         advance_cycle();
         // New request only once the old one is accepted or none was held
         for (int m = 0; m < NM; m++)
         begin
            if (c >= RAND_CYCLES - 1)
               m_req[m] = 1'b0;
            else if (!m_req[m] || pend[m])
            begin
               m_req[m] = (($random(seed) & 3) != 0);
               m_add[m] = addr_t'($random(seed));
            end
         end
      end
      check_val("random_traffic responses", 32'(accepts), 32'(resps));
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      seed   = 32'ha8c8;
      errors = 0;
      checks = 0;
      clk    = 1'b0;
      arst_n = 1'b0;
      m_req  = '0;
      m_add  = '0;
      stall  = '0;
      repeat (16) @(posedge clk);
      #2;
      arst_n = 1'b1;
      advance_cycle();
      single_access();
      bank_conflict();
      parallel_banks();
      back_pressure();
      random_traffic();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- ic_xbar_top.sv
// Read-only logarithmic interconnect, fetch masters to interleaved banks.
// One address decoder and one response block per master, one request block
// per bank. Requests reach the banks in the same cycle and responses come
// back one cycle after the accept, as set by the banks.

`include "ic_xbar_macros.svh"

module ic_xbar_top
(
   input  logic                                          clk,
   input  logic                                          arst_n_i,

   // Fetch master ports
   input  logic [`IC_N_MASTER-1:0]                       m_req_i,
   input  ic_xbar_pkg::addr_t [`IC_N_MASTER-1:0]         m_add_i,
   output logic [`IC_N_MASTER-1:0]                       m_gnt_o,
   output logic [`IC_N_MASTER-1:0]                       m_r_valid_o,
   output ic_xbar_pkg::rdata_t [`IC_N_MASTER-1:0]        m_r_rdata_o,

   // Memory bank ports
   output logic [`IC_N_BANK-1:0]                         b_req_o,
   output ic_xbar_pkg::addr_t [`IC_N_BANK-1:0]           b_add_o,
   output ic_xbar_pkg::master_id_t [`IC_N_BANK-1:0]      b_id_o,
   input  logic [`IC_N_BANK-1:0]                         b_gnt_i,
   input  logic [`IC_N_BANK-1:0]                         b_r_valid_i,
   input  ic_xbar_pkg::master_id_t [`IC_N_BANK-1:0]      b_r_id_i,
   input  ic_xbar_pkg::rdata_t [`IC_N_BANK-1:0]          b_r_rdata_i
);

   import ic_xbar_pkg::*;

   // Master-major rows as seen by decoders and response blocks
   logic [`IC_N_MASTER-1:0][`IC_N_BANK-1:0]   req_row;
   logic [`IC_N_MASTER-1:0][`IC_N_BANK-1:0]   gnt_row;
   logic [`IC_N_MASTER-1:0][`IC_N_BANK-1:0]   rvalid_row;
   bank_idx_t [`IC_N_MASTER-1:0]              bank_sel;

   // Bank-major columns as seen by request blocks
   logic [`IC_N_BANK-1:0][`IC_N_MASTER-1:0]   req_col;
   logic [`IC_N_BANK-1:0][`IC_N_MASTER-1:0]   gnt_col;
   logic [`IC_N_BANK-1:0][`IC_N_MASTER-1:0]   rvalid_col;

   ////////////////////////////////////////
   // Crossbar transpose
   ////////////////////////////////////////

   genvar m, b;
   generate
      for (m = 0; m < `IC_N_MASTER; m++)
      begin : gen_row
         for (b = 0; b < `IC_N_BANK; b++)
         begin : gen_col
            assign req_col[b][m]    = req_row[m][b];
            assign gnt_row[m][b]    = gnt_col[b][m];
            assign rvalid_row[m][b] = rvalid_col[b][m];
         end
      end
   endgenerate

   ////////////////////////////////////////
   // Master side
   ////////////////////////////////////////

   generate
      for (m = 0; m < `IC_N_MASTER; m++)
      begin : gen_master
         ic_addr_decoder_req u_dec
         (
            .req_i      ( m_req_i[m]  ),
            .add_i      ( m_add_i[m]  ),
            .gnt_o      ( m_gnt_o[m]  ),
            .bank_req_o ( req_row[m]  ),
            .bank_gnt_i ( gnt_row[m]  ),
            .bank_sel_o ( bank_sel[m] )
         );

         // Accept is the same-cycle req and gnt handshake
         ic_resp_block u_resp
         (
            .clk            ( clk                       ),
            .arst_n_i       ( arst_n_i                  ),
            .accept_i       ( m_req_i[m] & m_gnt_o[m]   ),
            .bank_sel_i     ( bank_sel[m]               ),
            .bank_r_valid_i ( rvalid_row[m]             ),
            .bank_r_rdata_i ( b_r_rdata_i               ),
            .r_valid_o      ( m_r_valid_o[m]            ),
            .r_rdata_o      ( m_r_rdata_o[m]            )
         );
      end
   endgenerate

   ////////////////////////////////////////
   // Bank side
   ////////////////////////////////////////

   generate
      for (b = 0; b < `IC_N_BANK; b++)
      begin : gen_bank
         // Every bank sees all master addresses, its column picks the owner
         ic_request_block u_rb
         (
            .clk            ( clk            ),
            .arst_n_i       ( arst_n_i       ),
            .req_i          ( req_col[b]     ),
            .add_i          ( m_add_i        ),
            .gnt_o          ( gnt_col[b]     ),
            .r_valid_o      ( rvalid_col[b]  ),
            .bank_req_o     ( b_req_o[b]     ),
            .bank_add_o     ( b_add_o[b]     ),
            .bank_id_o      ( b_id_o[b]      ),
            .bank_gnt_i     ( b_gnt_i[b]     ),
            .bank_r_valid_i ( b_r_valid_i[b] ),
            .bank_r_id_i    ( b_r_id_i[b]    )
         );
      end
   endgenerate

endmodule

//--- ic_resp_block.sv
// Response block for one fetch master.
// Remembers which bank accepted the master's last request and, one cycle
// later, returns that bank's r_valid bit and read data.
// Back-to-back accepts keep the pending flag set and reload the bank number.

`include "ic_xbar_macros.svh"

module ic_resp_block
(
   input  logic                                          clk,
   input  logic                                          arst_n_i,

   // Accept strobe and target bank from the request side
   input  logic                                          accept_i,
   input  ic_xbar_pkg::bank_idx_t                        bank_sel_i,

   // Per-bank response strobes for this master and shared bank read data
   input  logic [`IC_N_BANK-1:0]                         bank_r_valid_i,
   input  ic_xbar_pkg::rdata_t [`IC_N_BANK-1:0]          bank_r_rdata_i,

   // Master response
   output logic                                          r_valid_o,
   output ic_xbar_pkg::rdata_t                           r_rdata_o
);

   import ic_xbar_pkg::*;

   // A response is due in the current cycle
   logic      pending_q;

   // Bank that accepted the outstanding request
   bank_idx_t sel_q;

   ////////////////////////////////////////
   // Outstanding request tracking
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         pending_q <= 1'b0;
      else
         pending_q <= accept_i;
   end

   // Reloaded on every accept
   always_ff @(posedge clk)
   begin
      if (accept_i)
         sel_q <= bank_sel_i;
   end

   ////////////////////////////////////////
   // Response mux
   ////////////////////////////////////////

   // Strobe from the remembered bank only
   assign r_valid_o = pending_q & bank_r_valid_i[sel_q];

   // Read data of the remembered bank
   assign r_rdata_o = bank_r_rdata_i[sel_q];

   // No bank answers this master unless it has a request outstanding
   a_no_stray_resp : assert property (@(posedge clk) disable iff (!arst_n_i)
      !pending_q |-> (bank_r_valid_i == '0));

endmodule

//--- ic_addr_decoder_req.sv
// Request router for one fetch master.
// Takes the bank index from the word-interleaved address bits, raises the
// request toward that bank only and returns that bank's grant.
// The selected bank number also goes to the master's response block.

`include "ic_xbar_macros.svh"

module ic_addr_decoder_req
(
   // Master request
   input  logic                                          req_i,
   input  ic_xbar_pkg::addr_t                            add_i,
   output logic                                          gnt_o,

   // One row of the crossbar toward all banks
   output logic [`IC_N_BANK-1:0]                         bank_req_o,
   input  logic [`IC_N_BANK-1:0]                         bank_gnt_i,

   // Target bank for the response block
   output ic_xbar_pkg::bank_idx_t                        bank_sel_o
);

   import ic_xbar_pkg::*;

   ////////////////////////////////////////
   // Bank selection
   ////////////////////////////////////////

   // Index bits sit just above the word offset
   // A single bank always maps to bank 0
   generate
      if (`IC_N_BANK > 1)
      begin : gen_multi_bank
         assign bank_sel_o = add_i[`IC_BANK_LSB +: BANK_IDX_W];
      end
      else
      begin : gen_one_bank
         assign bank_sel_o = '0;
      end
   endgenerate

   // Only the selected bank sees the request
   always_comb
   begin
      for (int b = 0; b < `IC_N_BANK; b++)
      begin
         bank_req_o[b] = req_i && (bank_sel_o == bank_idx_t'(b));
      end
   end

   ////////////////////////////////////////
   // Grant return
   ////////////////////////////////////////

   // Grant comes only from the addressed bank
   assign gnt_o = bank_gnt_i[bank_sel_o];

   // Arbiter and bank together never grant an idle master
   always_comb
   begin
      a_no_gnt_idle : assert final (req_i || !gnt_o)
         else $error("grant returned to a master without a request");
   end

endmodule

//--- ic_request_block.sv
// Request block for one memory bank.
// Merges the bank's column of master requests into one bank port through
// the round-robin arbiter, or wires master 0 straight in when the crossbar
// has a single master.
// Also turns the bank's one-hot response ID into per-master r_valid pulses.

`include "ic_xbar_macros.svh"

module ic_request_block
(
   input  logic                                          clk,
   input  logic                                          arst_n_i,

   // Master side, one column of the crossbar
   input  logic [`IC_N_MASTER-1:0]                       req_i,
   input  ic_xbar_pkg::addr_t [`IC_N_MASTER-1:0]         add_i,
   output logic [`IC_N_MASTER-1:0]                       gnt_o,
   output logic [`IC_N_MASTER-1:0]                       r_valid_o,

   // Bank request port
   output logic                                          bank_req_o,
   output ic_xbar_pkg::addr_t                            bank_add_o,
   output ic_xbar_pkg::master_id_t                       bank_id_o,
   input  logic                                          bank_gnt_i,

   // Bank response strobe and owner
   input  logic                                          bank_r_valid_i,
   input  ic_xbar_pkg::master_id_t                       bank_r_id_i
);

   import ic_xbar_pkg::*;

   ////////////////////////////////////////
   // Request path
   ////////////////////////////////////////

   generate
      if (`IC_N_MASTER > 1)
      begin : gen_poly
         // Several masters share the bank
         ic_rr_arbiter u_arb
         (
            .clk      ( clk        ),
            .arst_n_i ( arst_n_i   ),
            .req_i    ( req_i      ),
            .add_i    ( add_i      ),
            .gnt_o    ( gnt_o      ),
            .req_o    ( bank_req_o ),
            .add_o    ( bank_add_o ),
            .id_o     ( bank_id_o  ),
            .gnt_i    ( bank_gnt_i )
         );
      end
      else
      begin : gen_mono
         // Lone master owns the bank, its ID is always bit 0
         assign bank_req_o = req_i[0];
         assign bank_add_o = add_i[0];
         assign bank_id_o  = master_id_t'(1);
         assign gnt_o[0]   = bank_gnt_i;
      end
   endgenerate

   ////////////////////////////////////////
   // Response valid decode
   ////////////////////////////////////////

   // Each master sees the strobe only when its ID bit is set
   always_comb
   begin
      for (int m = 0; m < `IC_N_MASTER; m++)
      begin
         r_valid_o[m] = bank_r_valid_i & bank_r_id_i[m];
      end
   end

   // Bank must name exactly one owner with every response
   a_rid_onehot : assert property (@(posedge clk) disable iff (!arst_n_i)
      bank_r_valid_i |-> $onehot(bank_r_id_i));

endmodule

//--- ic_rr_arbiter.sv
// Flat round-robin arbiter in front of one memory bank.
// Picks one requesting master per cycle, forwards its address and one-hot ID
// and hands the bank grant back to the winner only.
// The pointer moves past the winner only when the bank accepts.

`include "ic_xbar_macros.svh"

module ic_rr_arbiter
(
   input  logic                                          clk,
   input  logic                                          arst_n_i,

   // Master side, one column of the crossbar
   input  logic [`IC_N_MASTER-1:0]                       req_i,
   input  ic_xbar_pkg::addr_t [`IC_N_MASTER-1:0]         add_i,
   output logic [`IC_N_MASTER-1:0]                       gnt_o,

   // Bank side
   output logic                                          req_o,
   output ic_xbar_pkg::addr_t                            add_o,
   output ic_xbar_pkg::master_id_t                       id_o,
   input  logic                                          gnt_i
);

   import ic_xbar_pkg::*;

   // Master with top priority in the current cycle
   logic [MASTER_IDX_W-1:0] ptr_q;

   // Result of the combinational search
   logic [MASTER_IDX_W-1:0] winner;
   logic                    found;

   ////////////////////////////////////////
   // Winner search
   ////////////////////////////////////////

   // First requester at or after the pointer, wrapping past the last master
   always_comb
   begin : winner_search
      int idx;
      idx    = 0;
      found  = 1'b0;
      winner = '0;
      for (int i = 0; i < `IC_N_MASTER; i++)
      begin
         idx = (int'(ptr_q) + i) % `IC_N_MASTER;
         if (!found && req_i[idx])
         begin
            found  = 1'b1;
            winner = MASTER_IDX_W'(idx);
         end
      end
   end

   // Bank request follows any pending master
   assign req_o = found;
   assign add_o = add_i[winner];

   // ID stays zero while idle so the bank never sees a stale owner
   assign id_o  = found ? (master_id_t'(1) << winner) : '0;

   // Grant goes back only to the master named in the ID
   assign gnt_o = id_o & {`IC_N_MASTER{gnt_i}};

   ////////////////////////////////////////
   // Priority pointer
   ////////////////////////////////////////

   // Starts at master 0 and moves to winner plus one on each accept
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ptr_q <= '0;
      end
      else if (req_o && gnt_i)
      begin
         if (int'(winner) == `IC_N_MASTER - 1)
            ptr_q <= '0;
         else
            ptr_q <= winner + 1'b1;
      end
   end

   // Bank grant never reaches more than one master
   a_gnt_onehot0 : assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0(gnt_o));

   // Bank sees a request whenever some master waits on it
   a_no_lost_req : assert property (@(posedge clk) disable iff (!arst_n_i)
      (|req_i) |-> req_o);

endmodule

//--- ic_xbar_pkg.sv
// Shared types for the instruction-cache crossbar.
// Modules import this package inside their body and use scoped names on ports.
// All sizes follow the macros header.

`include "ic_xbar_macros.svh"

package ic_xbar_pkg;

   ////////////////////////////////////////
   // Derived index widths
   ////////////////////////////////////////

   // Bank number width, never below one bit
   localparam int BANK_IDX_W   = (`IC_N_BANK > 1) ? $clog2(`IC_N_BANK) : 1;

   // Master number width for the round-robin pointer
   localparam int MASTER_IDX_W = (`IC_N_MASTER > 1) ? $clog2(`IC_N_MASTER) : 1;

   ////////////////////////////////////////
   // Payload types
   ////////////////////////////////////////

   // Fetch address
   typedef logic [`IC_ADDR_WIDTH-1:0] addr_t;

   // Read data word
   typedef logic [`IC_DATA_WIDTH-1:0] rdata_t;

   // Bank number taken from the address
   typedef logic [BANK_IDX_W-1:0]     bank_idx_t;

   // One-hot master ID, bit m set means master m
   typedef logic [`IC_N_MASTER-1:0]   master_id_t;

endpackage

//--- ic_xbar_macros.svh
// Size and width constants for the read-only instruction-cache crossbar.
// Included by the package and by every RTL file that sizes a port.
// Change the master or bank count here. The bank count must be a power of two.

`ifndef IC_XBAR_MACROS_SVH
`define IC_XBAR_MACROS_SVH

////////////////////////////////////////
// Crossbar geometry
////////////////////////////////////////

// Fetch masters on the request side
`define IC_N_MASTER 4

// Interleaved memory banks on the bank side
`define IC_N_BANK 4

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

// Byte address from the fetch unit
`define IC_ADDR_WIDTH 32

// Read data word returned by a bank
`define IC_DATA_WIDTH 32

// Lowest address bit of the bank index
// Word interleaving puts consecutive words in consecutive banks
`define IC_BANK_LSB 2

`endif
